// ==== src/cp0_pkg.sv ====
package cp0_pkg;

	// cp0 register numbers, select 0 only
	localparam logic [4:0] badvaddr_num = 5'd8;
	localparam logic [4:0] count_num    = 5'd9;
	localparam logic [4:0] compare_num  = 5'd11;
	localparam logic [4:0] status_num   = 5'd12;
	localparam logic [4:0] cause_num    = 5'd13;
	localparam logic [4:0] epc_num      = 5'd14;

	// Cause.ExcCode values
	localparam logic [4:0] exccode_int  = 5'd0;
	localparam logic [4:0] exccode_adel = 5'd4;
	localparam logic [4:0] exccode_ades = 5'd5;
	localparam logic [4:0] exccode_sys  = 5'd8;
	localparam logic [4:0] exccode_bp   = 5'd9;
	localparam logic [4:0] exccode_ri   = 5'd10;
	localparam logic [4:0] exccode_ov   = 5'd12;

	// exception flags of one committed instruction, msb first
	typedef struct packed {
		// interrupt, merged in at commit
		logic int_f;
		// fetch address error
		logic adel_if;
		// load address error
		logic adel_d;
		// store address error
		logic ades;
		logic sys;
		logic bp;
		// reserved instruction
		logic ri;
		// overflow
		logic ov;
	} exc_flags_t;

endpackage

// ==== src/exc_if.sv ====
`timescale 1ns/10ps

interface exc_if;
	import cp0_pkg::*;

	// commit side
	exc_flags_t  exc;
	logic [31:0] exc_pc;
	logic        is_slot;
	logic [31:0] bad_addr;
	logic        eret;

	// cp0 side
	logic [31:0] epc;
	logic        int_pending;

	modport commit (
		output exc, exc_pc, is_slot, bad_addr, eret,
		input  epc, int_pending
	);

	modport cp0 (
		input  exc, exc_pc, is_slot, bad_addr, eret,
		output epc, int_pending
	);

endinterface

// ==== src/cp0_timer_if.sv ====
`timescale 1ns/10ps

interface cp0_timer_if;

	// mtc0 strobes from the register file
	logic        count_wen;
	logic        compare_wen;
	logic [31:0] wdata;

	// timer state back
	logic [31:0] count;
	logic [31:0] compare;
	logic        timer_irq;

	modport regs (
		output count_wen, compare_wen, wdata,
		input  count, compare, timer_irq
	);

	modport timer (
		input  count_wen, compare_wen, wdata,
		output count, compare, timer_irq
	);

endinterface

// ==== src/cp0_timer.sv ====
`timescale 1ns/10ps

module cp0_timer (
	input logic        clk,
	input logic        rst,
	cp0_timer_if.timer tmr
);

	logic        tick;
	logic [31:0] count_q;
	logic [31:0] compare_q;
	logic        irq_q;

	// half-rate enable for count
	always_ff @(posedge clk) begin
		if (rst) begin
			tick <= 1'b0;
		end else if (tmr.count_wen) begin
			tick <= 1'b0;
		end else begin
			tick <= ~tick;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			count_q <= '0;
		end else if (tmr.count_wen) begin
			count_q <= tmr.wdata;
		end else if (tick) begin
			count_q <= count_q + 32'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			compare_q <= '0;
		end else if (tmr.compare_wen) begin
			compare_q <= tmr.wdata;
		end
	end

	// compare write acknowledges the interrupt
	always_ff @(posedge clk) begin
		if (rst) begin
			irq_q <= 1'b0;
		end else if (tmr.compare_wen) begin
			irq_q <= 1'b0;
		end else if (count_q == compare_q) begin
			irq_q <= 1'b1;
		end
	end

	assign tmr.count     = count_q;
	assign tmr.compare   = compare_q;
	assign tmr.timer_irq = irq_q;

endmodule

// ==== src/cp0_regs.sv ====
`timescale 1ns/10ps

module cp0_regs (
	input  logic        clk,
	input  logic        rst,
	input  logic [7:0]  cp0_addr,
	input  logic        cp0_wen,
	input  logic [31:0] cp0_wdata,
	output logic [31:0] cp0_rdata,
	input  logic [5:0]  int_num,
	exc_if.cp0          exc,
	cp0_timer_if.regs   tmr
);
	import cp0_pkg::*;

	logic [4:0]  reg_num;
	logic        sel_ok;
	logic        wr_status;
	logic        wr_cause;
	logic        wr_epc;
	logic        any_exc;
	logic        addr_err;
	logic [4:0]  exccode;

	logic [7:0]  status_im;
	logic        status_exl;
	logic        status_ie;
	logic        cause_bd;
	logic [7:0]  cause_ip;
	logic [4:0]  cause_exccode;
	logic [31:0] epc_q;
	logic [31:0] badvaddr_q;
	logic [31:0] status_word;
	logic [31:0] cause_word;

	assign reg_num = cp0_addr[7:3];
	assign sel_ok  = cp0_addr[2:0] == 3'd0;

	assign wr_status = cp0_wen && sel_ok && reg_num == status_num;
	assign wr_cause  = cp0_wen && sel_ok && reg_num == cause_num;
	assign wr_epc    = cp0_wen && sel_ok && reg_num == epc_num;

	assign tmr.count_wen   = cp0_wen && sel_ok && reg_num == count_num;
	assign tmr.compare_wen = cp0_wen && sel_ok && reg_num == compare_num;
	assign tmr.wdata       = cp0_wdata;

	assign any_exc  = |exc.exc;
	assign addr_err = exc.exc.adel_if | exc.exc.adel_d | exc.exc.ades;

	// fetch error outranks ri, data errors come last
	always_comb begin
		if (exc.exc.int_f) begin
			exccode = exccode_int;
		end else if (exc.exc.adel_if) begin
			exccode = exccode_adel;
		end else if (exc.exc.ri) begin
			exccode = exccode_ri;
		end else if (exc.exc.sys) begin
			exccode = exccode_sys;
		end else if (exc.exc.bp) begin
			exccode = exccode_bp;
		end else if (exc.exc.ov) begin
			exccode = exccode_ov;
		end else if (exc.exc.adel_d) begin
			exccode = exccode_adel;
		end else if (exc.exc.ades) begin
			exccode = exccode_ades;
		end else begin
			exccode = exccode_int;
		end
	end

	// status, BEV is tied high
	always_ff @(posedge clk) begin
		if (rst) begin
			status_im  <= '0;
			status_exl <= 1'b0;
			status_ie  <= 1'b0;
		end else begin
			if (wr_status) begin
				status_im <= cp0_wdata[15:8];
				status_ie <= cp0_wdata[0];
			end
			if (any_exc) begin
				status_exl <= 1'b1;
			end else if (exc.eret) begin
				status_exl <= 1'b0;
			end else if (wr_status) begin
				status_exl <= cp0_wdata[1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cause_bd      <= 1'b0;
			cause_ip      <= '0;
			cause_exccode <= '0;
		end else begin
			// hardware lines sampled every cycle, timer shares IP7
			cause_ip[7:2] <= {int_num[5] | tmr.timer_irq, int_num[4:0]};
			if (wr_cause) begin
				cause_ip[1:0] <= cp0_wdata[9:8];
			end
			if (any_exc) begin
				cause_exccode <= exccode;
				if (!status_exl) begin
					cause_bd <= exc.is_slot;
				end
			end
		end
	end

	// nested exceptions keep the first return address
	always_ff @(posedge clk) begin
		if (rst) begin
			epc_q <= '0;
		end else if (any_exc && !status_exl) begin
			epc_q <= exc.is_slot ? exc.exc_pc - 32'd4 : exc.exc_pc;
		end else if (wr_epc) begin
			epc_q <= cp0_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			badvaddr_q <= '0;
		end else if (addr_err) begin
			badvaddr_q <= exc.bad_addr;
		end
	end

	assign status_word = {9'h0, 1'b1, 6'h0, status_im, 6'h0, status_exl, status_ie};
	assign cause_word  = {cause_bd, tmr.timer_irq, 14'h0, cause_ip, 1'b0, cause_exccode, 2'b0};

	always_comb begin
		cp0_rdata = '0;
		if (sel_ok) begin
			case (reg_num)
				badvaddr_num: cp0_rdata = badvaddr_q;
				count_num:    cp0_rdata = tmr.count;
				compare_num:  cp0_rdata = tmr.compare;
				status_num:   cp0_rdata = status_word;
				cause_num:    cp0_rdata = cause_word;
				epc_num:      cp0_rdata = epc_q;
				default:      cp0_rdata = '0;
			endcase
		end
	end

	assign exc.epc         = epc_q;
	assign exc.int_pending = !status_exl && status_ie && |(status_im & cause_ip);

endmodule

// ==== src/exc_commit.sv ====
`timescale 1ns/10ps

module exc_commit #(
	parameter logic [31:0] exc_entry = 32'hbfc0_0380
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        commit_valid,
	input  logic [6:0]  commit_exc,
	input  logic [31:0] commit_pc,
	input  logic        commit_is_slot,
	input  logic [31:0] commit_bad_vaddr,
	input  logic        commit_eret,
	output logic        flush,
	output logic [31:0] redirect_pc,
	output logic        int_happen,
	exc_if.commit       exc
);
	import cp0_pkg::*;

	exc_flags_t flags;
	logic       any_exc;
	logic       eret_ok;

	// nothing reaches cp0 without a committing instruction
	always_comb begin
		flags = '0;
		if (commit_valid) begin
			flags = {exc.int_pending, commit_exc};
		end
	end

	assign any_exc = |flags;
	// eret never travels with an exception
	assign eret_ok = commit_valid && commit_eret && !any_exc;

	assign exc.exc      = flags;
	assign exc.exc_pc   = commit_pc;
	assign exc.is_slot  = commit_is_slot;
	assign exc.bad_addr = flags.adel_if ? commit_pc : commit_bad_vaddr;
	assign exc.eret     = eret_ok;

	assign flush       = any_exc || eret_ok;
	assign redirect_pc = any_exc ? exc_entry : exc.epc;
	assign int_happen  = exc.int_pending;

endmodule

// ==== src/cp0_top.sv ====
`timescale 1ns/10ps

module cp0_top #(
	parameter logic [31:0] exc_entry = 32'hbfc0_0380
) (
	input  logic        clk,
	input  logic        rst,
	input  logic [7:0]  cp0_addr,
	input  logic        cp0_wen,
	input  logic [31:0] cp0_wdata,
	output logic [31:0] cp0_rdata,
	input  logic        commit_valid,
	input  logic [6:0]  commit_exc,
	input  logic [31:0] commit_pc,
	input  logic        commit_is_slot,
	input  logic [31:0] commit_bad_vaddr,
	input  logic        commit_eret,
	input  logic [5:0]  int_num,
	output logic        flush,
	output logic [31:0] redirect_pc,
	output logic        int_happen
);

	exc_if       exc_bus ();
	cp0_timer_if tmr_bus ();

	cp0_timer i_timer (
		.clk (clk),
		.rst (rst),
		.tmr (tmr_bus.timer)
	);

	cp0_regs i_regs (
		.clk       (clk),
		.rst       (rst),
		.cp0_addr  (cp0_addr),
		.cp0_wen   (cp0_wen),
		.cp0_wdata (cp0_wdata),
		.cp0_rdata (cp0_rdata),
		.int_num   (int_num),
		.exc       (exc_bus.cp0),
		.tmr       (tmr_bus.regs)
	);

	exc_commit #(
		.exc_entry (exc_entry)
	) i_commit (
		.clk              (clk),
		.rst              (rst),
		.commit_valid     (commit_valid),
		.commit_exc       (commit_exc),
		.commit_pc        (commit_pc),
		.commit_is_slot   (commit_is_slot),
		.commit_bad_vaddr (commit_bad_vaddr),
		.commit_eret      (commit_eret),
		.flush            (flush),
		.redirect_pc      (redirect_pc),
		.int_happen       (int_happen),
		.exc              (exc_bus.commit)
	);

endmodule

// ==== dv/cp0_props.sv ====
`timescale 1ns/10ps

module cp0_props #(
	parameter logic [31:0] exc_entry = 32'hbfc0_0380
) (
	input logic        clk,
	input logic        rst,
	input logic        commit_valid,
	input logic [6:0]  commit_exc,
	input logic        flush,
	input logic [31:0] redirect_pc,
	input logic        int_happen,
	input logic        status_exl
);

	// sticky flags, one per property
	logic flush_err = 1'b0;
	logic entry_err = 1'b0;
	logic exl_err   = 1'b0;

	logic exc_cycle;

	// exception cycle, interrupt included
	assign exc_cycle = commit_valid && (|commit_exc || int_happen);

	flush_needs_commit: assert property (@(posedge clk) disable iff (rst)
		!commit_valid |-> !flush)
	else begin
		$error("flush raised without a committing instruction");
		flush_err = 1'b1;
	end

	exc_goes_to_entry: assert property (@(posedge clk) disable iff (rst)
		exc_cycle |-> flush && redirect_pc == exc_entry)
	else begin
		$error("exception flush does not redirect to the entry address");
		entry_err = 1'b1;
	end

	no_int_under_exl: assert property (@(posedge clk) disable iff (rst)
		status_exl |-> !int_happen)
	else begin
		$error("int_happen raised while Status.EXL is set");
		exl_err = 1'b1;
	end

endmodule

bind cp0_top cp0_props #(
	.exc_entry (exc_entry)
) i_props (
	.clk          (clk),
	.rst          (rst),
	.commit_valid (commit_valid),
	.commit_exc   (commit_exc),
	.flush        (flush),
	.redirect_pc  (redirect_pc),
	.int_happen   (int_happen),
	.status_exl   (i_regs.status_exl)
);

// ==== dv/cp0_tb.sv ====
`timescale 1ns/10ps

module cp0_tb;
	import cp0_pkg::*;

	localparam logic [31:0] entry = 32'hbfc0_0380;

	logic        clk;
	logic        rst;
	logic [7:0]  cp0_addr;
	logic        cp0_wen;
	logic [31:0] cp0_wdata;
	logic [31:0] cp0_rdata;
	logic        commit_valid;
	logic [6:0]  commit_exc;
	logic [31:0] commit_pc;
	logic        commit_is_slot;
	logic [31:0] commit_bad_vaddr;
	logic        commit_eret;
	logic [5:0]  int_num;
	logic        flush;
	logic [31:0] redirect_pc;
	logic        int_happen;

	integer      seed;
	logic [31:0] r;
	logic [31:0] c0;
	logic [6:0]  f;
	logic [4:0]  num;
	// rising edges since reset
	logic [31:0] cycles;
	// reference model of the cp0 state
	logic [7:0]  m_im;
	logic [5:0]  m_hw;
	logic [1:0]  m_sw;
	logic [4:0]  m_code;
	logic        m_exl;
	logic        m_ie;
	logic        m_ti;
	logic        m_bd;
	logic [31:0] m_epc;
	logic [31:0] m_bad;
	logic [31:0] m_cmp;

	cp0_top #(.exc_entry(entry)) i_cp0_top (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		if (rst) begin
			cycles <= '0;
		end else begin
			cycles <= cycles + 32'd1;
		end
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else
			stop_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
	endtask

	function automatic logic props_failed();
		return i_cp0_top.i_props.flush_err || i_cp0_top.i_props.entry_err ||
			i_cp0_top.i_props.exl_err;
	endfunction

	always @(negedge clk) begin
		if (props_failed()) begin
			stop_run("a concurrent assertion in cp0_props failed");
		end
	end

	// msb to lsb int adel_if adel_d ades sys bp ri ov
	function automatic logic [4:0] prio_code(input logic intr, input logic [6:0] fl);
		casez ({intr, fl})
			8'b1???????: return exccode_int;
			8'b?1??????: return exccode_adel;
			8'b??????1?: return exccode_ri;
			8'b????1???: return exccode_sys;
			8'b?????1??: return exccode_bp;
			8'b???????1: return exccode_ov;
			8'b??1?????: return exccode_adel;
			default:     return exccode_ades;
		endcase
	endfunction

	task automatic read_check(input logic [4:0] n, input logic [2:0] sel,
			input logic [31:0] exp, input string name);
		cp0_addr = {n, sel};
		#2;
		check(name, cp0_rdata, exp);
		@(negedge clk);
	endtask

	task automatic check_regs();
		read_check(status_num, 3'd0, {9'h0, 1'b1, 6'h0, m_im, 6'h0, m_exl, m_ie}, "status");
		read_check(cause_num, 3'd0, {m_bd, m_ti, 14'h0, m_hw, m_sw, 1'b0, m_code, 2'b0},
			"cause");
		read_check(epc_num, 3'd0, m_epc, "epc");
		read_check(badvaddr_num, 3'd0, m_bad, "badvaddr");
		read_check(compare_num, 3'd0, m_cmp, "compare");
	endtask

	task automatic mtc0(input logic [4:0] n, input logic [31:0] d);
		cp0_addr  = {n, 3'd0};
		cp0_wdata = d;
		cp0_wen   = 1'b1;
		@(negedge clk);
		cp0_wen   = 1'b0;
		case (n)
			status_num: {m_im, m_exl, m_ie} = {d[15:8], d[1], d[0]};
			cause_num:  m_sw = d[9:8];
			epc_num:    m_epc = d;
			compare_num: begin
				m_cmp = d;
				m_ti  = 1'b0;
			end
			default: ;
		endcase
	endtask

	// waits for Cause.TI when ti is set and for int_happen when not
	task automatic wait_for(input logic ti);
		integer n;
		n = 0;
		cp0_addr = {cause_num, 3'd0};
		#2;
		while (ti ? !cp0_rdata[30] : !int_happen) begin
			n = n + 1;
			if (n > 40) begin
				if (ti) begin
					stop_run("timeout waiting for Cause.TI");
				end else begin
					stop_run("timeout waiting for int_happen");
				end
			end
			@(negedge clk);
			#2;
		end
		@(negedge clk);
	endtask

	task automatic commit(input logic [6:0] fl, input logic eret);
		logic [31:0] pc;
		logic [31:0] bad;
		logic        intr;
		pc = $random(seed) & 32'hffff_fffc;
		bad = $random(seed);
		r = $random(seed);
		intr = !m_exl && m_ie && (|(m_im & {m_hw, m_sw}));
		commit_valid = 1'b1;
		commit_exc = fl;
		commit_pc = pc;
		commit_is_slot = r[0];
		commit_bad_vaddr = bad;
		commit_eret = eret;
		#2;
		check("int_happen", {31'd0, int_happen}, {31'd0, intr});
		check("flush", {31'd0, flush}, 32'd1);
		if (fl != 7'd0 || intr) begin
			check("redirect_pc", redirect_pc, entry);
			m_code = prio_code(intr, fl);
			if (!m_exl) begin
				m_epc = r[0] ? pc - 32'd4 : pc;
				m_bd  = r[0];
			end
			if (fl[6]) begin
				m_bad = pc;
			end else if (fl[5] || fl[4]) begin
				m_bad = bad;
			end
			m_exl = 1'b1;
		end else begin
			check("redirect_pc", redirect_pc, m_epc);
			m_exl = 1'b0;
		end
		@(negedge clk);
		commit_valid = 1'b0;
		commit_exc = '0;
		commit_eret = 1'b0;
	endtask

	initial begin
		seed = 32'hcaf1;
		rst = 1'b1;
		cp0_addr = '0;
		cp0_wen = 1'b0;
		cp0_wdata = '0;
		int_num = '0;
		commit_valid = 1'b0;
		commit_exc = '0;
		commit_pc = '0;
		commit_is_slot = 1'b0;
		commit_bad_vaddr = '0;
		commit_eret = 1'b0;
		m_im = '0;
		m_hw = '0;
		m_sw = '0;
		m_code = '0;
		m_exl = 1'b0;
		m_ie = 1'b0;
		m_ti = 1'b0;
		m_bd = 1'b0;
		m_epc = '0;
		m_bad = '0;
		m_cmp = '0;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		check("flush", {31'd0, flush}, 32'd0);
		check("int_happen", {31'd0, int_happen}, 32'd0);
		// park compare well above count
		r = $random(seed);
		mtc0(compare_num, r | 32'h8000_0000);
		check_regs();

		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			c0 = $random(seed);
			case (r[1:0])
				2'd0: num = status_num;
				2'd1: num = cause_num;
				2'd2: num = epc_num;
				default: begin
					num = compare_num;
					c0[31] = 1'b1;
				end
			endcase
			mtc0(num, c0);
			check_regs();
		end
		read_check(5'd3, 3'd0, 32'd0, "cp0 reg 3");
		read_check(status_num, 3'd1, 32'd0, "status sel 1");

		// single flags first and random mixes after
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			f = (i < 7) ? 7'd1 << i : r[6:0];
			if (f == 7'd0) begin
				f = 7'h02;
			end
			// odd rounds nest on the previous exception
			if (i % 2 == 0) begin
				mtc0(status_num, 32'd0);
			end
			commit(f, 1'b0);
			check_regs();
		end
		commit(7'd0, 1'b1);
		check_regs();

		// software interrupt on IP0
		mtc0(cause_num, 32'h0000_0100);
		mtc0(status_num, 32'h0000_0101);
		wait_for(1'b0);
		commit(7'd0, 1'b0);
		check_regs();
		// hardware line 0 lands in IP2
		mtc0(status_num, 32'h0000_0401);
		int_num = 6'h01;
		m_hw = 6'h01;
		wait_for(1'b0);
		commit(7'd0, 1'b0);
		int_num = 6'h00;
		m_hw = 6'h00;
		@(negedge clk);
		check_regs();

		// count is half the number of edges since reset
		for (int i = 0; i < 4; i++) begin
			read_check(count_num, 3'd0, cycles >> 1, "count");
		end
		c0 = cycles >> 1;
		mtc0(compare_num, c0 + 32'd4);
		wait_for(1'b1);
		m_ti = 1'b1;
		m_hw = 6'h20;
		check_regs();
		mtc0(compare_num, c0 | 32'h8000_0000);
		m_hw = 6'h00;
		check_regs();

		if (props_failed()) begin
			stop_run("a concurrent assertion in cp0_props failed");
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

// ==== verilog.f ====
src/cp0_pkg.sv
src/exc_if.sv
src/cp0_timer_if.sv
src/cp0_timer.sv
src/cp0_regs.sv
src/exc_commit.sv
src/cp0_top.sv
dv/cp0_props.sv
dv/cp0_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = cp0_tb
RTL_TOP    = cp0_top
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
